// ==== include/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data and address width
`define CPU_XLEN 32

// Integer register file
`define CPU_NUM_REGS  32
`define CPU_REG_IDX_W 5

// First fetch address after reset
`define CPU_VEC_RESET 32'hFF10_0000

`endif

// ==== verilog/rv_isa_pkg.sv ====
`include "cpu_macros.svh"

package rv_isa_pkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        BRANCH   = 7'b1100011,
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        OP_IMM   = 7'b0010011,
        OP       = 7'b0110011,
        MISC_MEM = 7'b0001111
    } opcode_e;

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b1000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        SRA  = 4'b1101,
        OR   = 4'b0110,
        AND  = 4'b0111
    } alu_op_e;

    typedef struct packed {
        logic                      is_lui;
        logic                      is_auipc;
        logic                      is_jal;
        logic                      is_jalr;
        logic                      is_branch;
        logic                      is_load;
        logic                      is_store;
        logic                      is_alu_imm;
        logic                      is_alu_reg;
        logic [2:0]                funct3;
        alu_op_e                   alu_op;
        logic [`CPU_REG_IDX_W-1:0] rs1;
        logic [`CPU_REG_IDX_W-1:0] rs2;
        logic [`CPU_REG_IDX_W-1:0] rd;
        logic [`CPU_XLEN-1:0]      imm;      // Sign extended, per format
        logic                      use_imm;  // Right ALU operand is imm
    } decoded_t;

endpackage

// ==== verilog/cpu_bus_pkg.sv ====
`include "cpu_macros.svh"

package cpu_bus_pkg;

    // Request side of the strobe/wait memory bus
    typedef struct packed {
        logic [`CPU_XLEN-1:0] addr;    // Word aligned
        logic [`CPU_XLEN-1:0] wrdata;
        logic                 wren;
        logic                 strobe;  // Transfer in progress
    } bus_req_t;

endpackage

// ==== verilog/cpu_decode.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_decode (
    input  logic [`CPU_XLEN-1:0] instr,
    output rv_isa_pkg::decoded_t dec
);

    rv_isa_pkg::opcode_e  opcode;
    logic                 alt_op;  // funct7 bit 5
    logic [`CPU_XLEN-1:0] imm_i;
    logic [`CPU_XLEN-1:0] imm_s;
    logic [`CPU_XLEN-1:0] imm_b;
    logic [`CPU_XLEN-1:0] imm_u;
    logic [`CPU_XLEN-1:0] imm_j;

    assign opcode = rv_isa_pkg::opcode_e'(instr[6:0]);
    assign alt_op = instr[30];

    assign imm_i = {{21{instr[31]}}, instr[30:20]};
    assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec        = '0;
        dec.funct3 = instr[14:12];
        dec.rs1    = instr[19:15];
        dec.rs2    = instr[24:20];  // Also the shift amount of SLLI/SRLI/SRAI
        dec.rd     = instr[11:7];

        case (opcode)
            rv_isa_pkg::LUI: begin
                dec.is_lui = 1'b1;
                dec.imm    = imm_u;
            end
            rv_isa_pkg::AUIPC: begin
                dec.is_auipc = 1'b1;
                dec.imm      = imm_u;
            end
            rv_isa_pkg::JAL: begin
                dec.is_jal = 1'b1;
                dec.imm    = imm_j;
            end
            rv_isa_pkg::JALR: begin
                dec.is_jalr = 1'b1;
                dec.imm     = imm_i;
            end
            rv_isa_pkg::BRANCH: begin
                dec.is_branch = 1'b1;
                dec.imm       = imm_b;
            end
            rv_isa_pkg::LOAD: begin
                dec.is_load = 1'b1;
                dec.imm     = imm_i;
            end
            rv_isa_pkg::STORE: begin
                dec.is_store = 1'b1;
                dec.imm      = imm_s;
            end
            rv_isa_pkg::OP_IMM: begin
                dec.is_alu_imm = 1'b1;
                dec.imm        = imm_i;
                dec.use_imm    = 1'b1;
            end
            rv_isa_pkg::OP: dec.is_alu_reg = 1'b1;
            default: ;  // FENCE and unknown opcodes run as no-ops
        endcase

        case (instr[14:12])
            3'b000:  dec.alu_op = (dec.is_alu_reg && alt_op) ? rv_isa_pkg::SUB : rv_isa_pkg::ADD;
            3'b001:  dec.alu_op = rv_isa_pkg::SLL;
            3'b010:  dec.alu_op = rv_isa_pkg::SLT;
            3'b011:  dec.alu_op = rv_isa_pkg::SLTU;
            3'b100:  dec.alu_op = rv_isa_pkg::XOR;
            3'b101:  dec.alu_op = alt_op ? rv_isa_pkg::SRA : rv_isa_pkg::SRL;  // Both forms
            3'b110:  dec.alu_op = rv_isa_pkg::OR;
            default: dec.alu_op = rv_isa_pkg::AND;
        endcase
    end

endmodule

// ==== verilog/cpu_regfile.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_regfile (
    input  logic                      clk,
    input  logic [`CPU_REG_IDX_W-1:0] rs1,
    input  logic [`CPU_REG_IDX_W-1:0] rs2,
    input  logic [`CPU_REG_IDX_W-1:0] rd,
    input  logic                      rd_wr,
    input  logic [`CPU_XLEN-1:0]      rd_data,
    output logic [`CPU_XLEN-1:0]      rs1_data,
    output logic [`CPU_XLEN-1:0]      rs2_data
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rd_wr && rd != '0) begin  // x0 is never written
            regs[rd] <= rd_data;
        end
    end

    // Asynchronous reads, x0 forced to zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== verilog/cpu_alu.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_alu (
    input  rv_isa_pkg::decoded_t dec,
    input  logic [`CPU_XLEN-1:0] rs1_data,
    input  logic [`CPU_XLEN-1:0] rs2_data,
    output logic [`CPU_XLEN-1:0] result,
    output logic [`CPU_XLEN-1:0] sum,
    output logic                 take_branch
);

    logic [`CPU_XLEN-1:0] r_op;
    logic [4:0]           shamt;
    logic [`CPU_XLEN:0]   diff;
    logic                 is_eq;
    logic                 is_lt;
    logic                 is_ltu;
    logic                 shr_msb;
    logic [`CPU_XLEN-1:0] shl1, shl2, shl4, shl8, shl16;
    logic [`CPU_XLEN-1:0] shr1, shr2, shr4, shr8, shr16;

    assign r_op  = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = r_op[4:0];

    // JALR target and load/store address
    assign sum = rs1_data + dec.imm;

    ////////////////////////////////////////
    // Compare
    ////////////////////////////////////////
    assign diff   = {1'b0, rs1_data} - {1'b0, r_op};
    assign is_eq  = (diff[`CPU_XLEN-1:0] == '0);
    assign is_ltu = diff[`CPU_XLEN];
    assign is_lt  = (rs1_data[`CPU_XLEN-1] ^ r_op[`CPU_XLEN-1]) ? rs1_data[`CPU_XLEN-1] : is_ltu;

    ////////////////////////////////////////
    // Barrel shifters
    ////////////////////////////////////////
    assign shl1  = shamt[0] ? {rs1_data[30:0], 1'b0} : rs1_data;
    assign shl2  = shamt[1] ? {shl1[29:0], 2'b0} : shl1;
    assign shl4  = shamt[2] ? {shl2[27:0], 4'b0} : shl2;
    assign shl8  = shamt[3] ? {shl4[23:0], 8'b0} : shl4;
    assign shl16 = shamt[4] ? {shl8[15:0], 16'b0} : shl8;

    assign shr_msb = (dec.alu_op == rv_isa_pkg::SRA) ? rs1_data[`CPU_XLEN-1] : 1'b0;
    assign shr1  = shamt[0] ? {{1{shr_msb}}, rs1_data[31:1]} : rs1_data;
    assign shr2  = shamt[1] ? {{2{shr_msb}}, shr1[31:2]} : shr1;
    assign shr4  = shamt[2] ? {{4{shr_msb}}, shr2[31:4]} : shr2;
    assign shr8  = shamt[3] ? {{8{shr_msb}}, shr4[31:8]} : shr4;
    assign shr16 = shamt[4] ? {{16{shr_msb}}, shr8[31:16]} : shr8;

    always_comb begin
        case (dec.alu_op)
            rv_isa_pkg::ADD:  result = rs1_data + r_op;
            rv_isa_pkg::SUB:  result = diff[`CPU_XLEN-1:0];
            rv_isa_pkg::SLL:  result = shl16;
            rv_isa_pkg::SLT:  result = {{(`CPU_XLEN-1){1'b0}}, is_lt};
            rv_isa_pkg::SLTU: result = {{(`CPU_XLEN-1){1'b0}}, is_ltu};
            rv_isa_pkg::XOR:  result = rs1_data ^ r_op;
            rv_isa_pkg::SRL,
            rv_isa_pkg::SRA:  result = shr16;
            rv_isa_pkg::OR:   result = rs1_data | r_op;
            rv_isa_pkg::AND:  result = rs1_data & r_op;
            default:          result = '0;
        endcase
    end

    // Branches compare against rs2, use_imm is low for them
    always_comb begin
        take_branch = 1'b0;
        if (dec.is_branch) begin
            case (dec.funct3)
                3'b000:  take_branch = is_eq;    // BEQ
                3'b001:  take_branch = !is_eq;   // BNE
                3'b100:  take_branch = is_lt;    // BLT
                3'b101:  take_branch = !is_lt;   // BGE
                3'b110:  take_branch = is_ltu;   // BLTU
                3'b111:  take_branch = !is_ltu;  // BGEU
                default: take_branch = 1'b0;
            endcase
        end
    end

endmodule

// ==== verilog/cpu_control.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_control (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  bus_wait,
    input  logic [`CPU_XLEN-1:0]  bus_rddata,
    output cpu_bus_pkg::bus_req_t bus_req,
    output logic [`CPU_XLEN-1:0]  instr,
    input  rv_isa_pkg::decoded_t  dec,
    input  logic [`CPU_XLEN-1:0]  rs2_data,
    input  logic [`CPU_XLEN-1:0]  alu_result,
    input  logic [`CPU_XLEN-1:0]  alu_sum,
    input  logic                  take_branch,
    output logic                  rd_wr,
    output logic [`CPU_XLEN-1:0]  rd_data
);

    typedef enum logic [1:0] {
        FETCH,
        MEM_RD,
        MEM_WR
    } state_e;

    state_e                state_q, state_d;
    logic [`CPU_XLEN-1:0]  pc_q, pc_d;
    logic [`CPU_XLEN-1:0]  instr_q, instr_d;
    cpu_bus_pkg::bus_req_t req_q, req_d;

    logic [`CPU_XLEN-1:0]  pc_plus4;
    logic [`CPU_XLEN-1:0]  pc_plus_imm;
    logic [`CPU_XLEN-1:0]  next_pc;
    logic                  go_fetch;
    logic [`CPU_XLEN-1:0]  fetch_pc;

    assign bus_req = req_q;

    // Fetched word goes straight to decode, held word afterwards
    assign instr = (state_q == FETCH) ? bus_rddata : instr_q;

    assign pc_plus4    = pc_q + 32'd4;
    assign pc_plus_imm = pc_q + dec.imm;

    ////////////////////////////////////////
    // Writeback and next PC
    ////////////////////////////////////////
    always_comb begin
        if (dec.is_lui) begin
            rd_data = dec.imm;
        end else if (dec.is_auipc) begin
            rd_data = pc_plus_imm;
        end else if (dec.is_jal || dec.is_jalr) begin
            rd_data = pc_plus4;  // Link address
        end else if (dec.is_load) begin
            rd_data = bus_rddata;
        end else if (dec.is_alu_imm || dec.is_alu_reg) begin
            rd_data = alu_result;
        end else begin
            rd_data = '0;
        end
    end

    always_comb begin
        if (dec.is_jal || take_branch) begin
            next_pc = pc_plus_imm;
        end else if (dec.is_jalr) begin
            next_pc = {alu_sum[`CPU_XLEN-1:1], 1'b0};
        end else begin
            next_pc = pc_plus4;
        end
    end

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////
    always_comb begin
        state_d  = state_q;
        pc_d     = pc_q;
        instr_d  = instr_q;
        req_d    = req_q;
        rd_wr    = 1'b0;
        go_fetch = 1'b0;
        fetch_pc = pc_plus4;

        case (state_q)
            FETCH: begin
                if (!bus_wait) begin
                    instr_d = bus_rddata;
                    if (dec.is_load || dec.is_store) begin
                        state_d      = dec.is_load ? MEM_RD : MEM_WR;
                        req_d.addr   = {alu_sum[`CPU_XLEN-1:2], 2'b00};  // Low bits dropped
                        req_d.wrdata = rs2_data;
                        req_d.wren   = dec.is_store;
                        req_d.strobe = 1'b1;
                    end else begin
                        rd_wr    = dec.is_lui || dec.is_auipc || dec.is_jal || dec.is_jalr ||
                                   dec.is_alu_imm || dec.is_alu_reg;
                        go_fetch = 1'b1;
                        fetch_pc = next_pc;
                    end
                end
            end
            MEM_RD: begin
                if (!bus_wait) begin
                    rd_wr    = 1'b1;  // Load word written at completion
                    go_fetch = 1'b1;
                end
            end
            MEM_WR: begin
                if (!bus_wait) begin
                    go_fetch = 1'b1;
                end
            end
            default: state_d = FETCH;
        endcase

        if (go_fetch) begin
            state_d      = FETCH;
            pc_d         = fetch_pc;
            req_d.addr   = {fetch_pc[`CPU_XLEN-1:2], 2'b00};
            req_d.wren   = 1'b0;
            req_d.strobe = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= FETCH;
            pc_q    <= `CPU_VEC_RESET;
            req_q   <= '{addr: `CPU_VEC_RESET, wrdata: '0, wren: 1'b0, strobe: 1'b1};
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
            req_q   <= req_d;
        end
    end

    always_ff @(posedge clk) begin
        instr_q <= instr_d;
    end

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu (
    input  logic                  clk,
    input  logic                  reset,
    output cpu_bus_pkg::bus_req_t bus_req,
    input  logic                  bus_wait,
    input  logic [`CPU_XLEN-1:0]  bus_rddata
);

    logic [`CPU_XLEN-1:0] instr;
    rv_isa_pkg::decoded_t dec;
    logic [`CPU_XLEN-1:0] rs1_data;
    logic [`CPU_XLEN-1:0] rs2_data;
    logic [`CPU_XLEN-1:0] alu_result;
    logic [`CPU_XLEN-1:0] alu_sum;
    logic                 take_branch;
    logic                 rd_wr;
    logic [`CPU_XLEN-1:0] rd_data;

    cpu_control control_inst (
        .clk         (clk),
        .reset       (reset),
        .bus_wait    (bus_wait),
        .bus_rddata  (bus_rddata),
        .bus_req     (bus_req),
        .instr       (instr),
        .dec         (dec),
        .rs2_data    (rs2_data),
        .alu_result  (alu_result),
        .alu_sum     (alu_sum),
        .take_branch (take_branch),
        .rd_wr       (rd_wr),
        .rd_data     (rd_data)
    );

    cpu_decode decode_inst (
        .instr (instr),
        .dec   (dec)
    );

    cpu_regfile regfile_inst (
        .clk      (clk),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rd       (dec.rd),
        .rd_wr    (rd_wr),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    cpu_alu alu_inst (
        .dec         (dec),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .result      (alu_result),
        .sum         (alu_sum),
        .take_branch (take_branch)
    );

endmodule

// ==== verif/cpu_tb.sv ====
`timescale 1ns/10ps
`include "cpu_macros.svh"

module cpu_tb;

    localparam int MEM_WORDS  = 256;   // 1 KB at the reset vector
    localparam int RES_BASE   = 640;   // Byte offset of the result area
    localparam int DATA_OFF   = 800;   // Preloaded load operand
    localparam int SKIP_OFF   = 900;   // Only written by a store that must be skipped
    localparam int STORE_WAIT = 2000;  // Cycles allowed per store

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  bus_wait;
    logic [`CPU_XLEN-1:0]  bus_rddata;
    cpu_bus_pkg::bus_req_t bus_req;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] log_addr [$];  // Completed writes in bus order
    logic [31:0] log_data [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    integer      seed;
    int          pc_idx;
    int          res_off;
    int          reset_cycles;
    int          checked;
    bit          seen_first;
    int          value_errors;
    int          other_errors;

    cpu cpu_inst (
        .clk        (clk),
        .reset      (reset),
        .bus_req    (bus_req),
        .bus_wait   (bus_wait),
        .bus_rddata (bus_rddata)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////
    function automatic logic [31:0] r_type(input logic [3:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {(op[3] ? 7'h20 : 7'h00), rs2, rs1, op[2:0], rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};  // SW only
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // Expected RV32I result for op {funct7[5], funct3}
    function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            4'b0000: return a + b;
            4'b1000: return a - b;
            4'b0001: return a << b[4:0];
            4'b0010: return {31'b0, $signed(a) < $signed(b)};
            4'b0011: return {31'b0, a < b};
            4'b0100: return a ^ b;
            4'b0101: return a >> b[4:0];
            4'b1101: return $signed(a) >>> b[4:0];
            4'b0110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] here();
        return `CPU_VEC_RESET + 32'(pc_idx) * 4;
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[pc_idx] = word;
        pc_idx++;
    endtask

    // LUI+ADDI pair with the upper part rounded for the signed low part
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h800;
        emit(u_type(hi[31:12], rd, OPC_LUI));
        emit(i_type(value[11:0], rd, 3'b000, rd, OPC_OP_IMM));
    endtask

    // SW to the next result slot off the base in x5
    task automatic store_result(input logic [4:0] rs2, input logic [31:0] value);
        emit(s_type(12'(res_off), rs2, 5'd5));
        exp_addr.push_back(`CPU_VEC_RESET + RES_BASE + res_off);
        exp_data.push_back(value);
        res_off += 4;
    endtask

    ////////////////////////////////////////
    // Program
    ////////////////////////////////////////
    task automatic build_program();
        logic [3:0]  reg_ops [10];
        logic [3:0]  imm_ops [9];
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic [19:0] upper;
        logic [31:0] at;
        reg_ops = '{4'b0000, 4'b1000, 4'b0111, 4'b0110, 4'b0100,
                    4'b0010, 4'b0011, 4'b0001, 4'b0101, 4'b1101};
        imm_ops = '{4'b0000, 4'b0100, 4'b0110, 4'b0111, 4'b0010,
                    4'b0011, 4'b0001, 4'b0101, 4'b1101};
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (`CPU_VEC_RESET + 32'(i) * 4) ^ 32'h5A5A_0000;
        end
        pc_idx  = 0;
        res_off = 0;
        load_const(5'd5, `CPU_VEC_RESET + RES_BASE);
        emit(i_type(12'h0ff, 5'd0, 3'b000, 5'd0, OPC_FENCE));  // Runs as a no-op

        foreach (reg_ops[i]) begin
            a = $random(seed);
            b = $random(seed);
            load_const(5'd6, a);
            load_const(5'd7, b);
            emit(r_type(reg_ops[i], 5'd8, 5'd6, 5'd7));
            store_result(5'd8, alu_ref(reg_ops[i], a, b));
        end

        foreach (imm_ops[i]) begin
            a   = $random(seed);
            imm = $random(seed);
            if (imm_ops[i][1:0] == 2'b01) begin
                imm = {1'b0, imm_ops[i][3], 5'b0, imm[4:0]};  // Shift form
            end
            load_const(5'd6, a);
            emit(i_type(imm, 5'd6, imm_ops[i][2:0], 5'd8, OPC_OP_IMM));
            store_result(5'd8, alu_ref(imm_ops[i], a, {{20{imm[11]}}, imm}));
        end

        a = $random(seed);
        mem[DATA_OFF / 4] = a;
        emit(i_type(12'(DATA_OFF - RES_BASE), 5'd5, 3'b010, 5'd9, OPC_LOAD));
        emit(i_type(12'd1, 5'd9, 3'b000, 5'd9, OPC_OP_IMM));
        store_result(5'd9, a + 1);

        load_const(5'd11, 32'hBAD0_0BAD);
        load_const(5'd12, 32'h600D_0001);
        load_const(5'd13, 32'h600D_0002);
        load_const(5'd18, 32'h600D_00FF);

        emit(b_type(13'd8, 5'd0, 5'd0, 3'b000));  // BEQ taken
        emit(s_type(12'(SKIP_OFF - RES_BASE), 5'd11, 5'd5));
        store_result(5'd12, 32'h600D_0001);
        emit(b_type(13'd8, 5'd0, 5'd0, 3'b001));  // BNE falls through
        store_result(5'd13, 32'h600D_0002);

        at = here();
        emit(j_type(21'd8, 5'd14));
        emit(s_type(12'(SKIP_OFF - RES_BASE), 5'd11, 5'd5));
        store_result(5'd14, at + 4);

        upper = $random(seed);
        at    = here();
        emit(u_type(upper, 5'd15, OPC_AUIPC));
        store_result(5'd15, at + {upper, 12'b0});

        // Odd JALR offset lands on at+12
        at = here();
        emit(u_type(20'd0, 5'd16, OPC_AUIPC));
        emit(i_type(12'd13, 5'd16, 3'b000, 5'd17, OPC_JALR));
        emit(s_type(12'(SKIP_OFF - RES_BASE), 5'd11, 5'd5));
        store_result(5'd17, at + 8);
        store_result(5'd18, 32'h600D_00FF);  // Final marker
        emit(j_type(21'd0, 5'd0));           // Park
    endtask

    ////////////////////////////////////////
    // Memory model and reset
    ////////////////////////////////////////
    always @(negedge clk) begin : memory_model
        logic [31:0] offs;
        logic        in_range;
        if (reset) begin
            reset_cycles++;
            if (reset_cycles == 3) begin
                reset = 1'b0;
            end
        end else begin
            bus_wait   = ($random(seed) & 3) == 0;  // One cycle in four stalls
            offs       = bus_req.addr - `CPU_VEC_RESET;
            in_range   = offs < 4 * MEM_WORDS;
            bus_rddata = in_range ? mem[offs[9:2]] : '0;
            if (bus_req.strobe && !bus_wait) begin
                if (!seen_first) begin
                    seen_first = 1'b1;
                    assert (bus_req.addr == `CPU_VEC_RESET && !bus_req.wren) else begin
                        value_errors++;
                        $display("** Error at %0t: first transfer %h wren %b not a read at %h",
                                 $time, bus_req.addr, bus_req.wren, `CPU_VEC_RESET);
                    end
                end
                assert (in_range) else begin
                    other_errors++;
                    $display("Bus transfer to %h lies outside the memory model", bus_req.addr);
                end
                if (in_range && bus_req.wren) begin
                    mem[offs[9:2]] = bus_req.wrdata;
                    log_addr.push_back(bus_req.addr);
                    log_data.push_back(bus_req.wrdata);
                end
            end
        end
    end

    // Compares each logged store in order with the expected table
    task automatic check_stores(output int count);
        int          n;
        int          cycles;
        logic [31:0] addr;
        logic [31:0] data;
        n = 0;
        while (n < exp_addr.size()) begin
            cycles = 0;
            while (log_addr.size() == 0 && cycles < STORE_WAIT) begin
                @(posedge clk);
                cycles++;
            end
            if (log_addr.size() == 0) begin
                other_errors++;
                $display("Timeout: store %0d of %0d did not arrive within %0d cycles",
                         n + 1, exp_addr.size(), STORE_WAIT);
                break;
            end
            addr = log_addr.pop_front();
            data = log_data.pop_front();
            assert (addr != `CPU_VEC_RESET + SKIP_OFF) else begin
                value_errors++;
                $display("** Error at %0t: a store that should be skipped wrote %h",
                         $time, data);
            end
            assert (addr == exp_addr[n] && data == exp_data[n]) else begin
                value_errors++;
                $display("** Error at %0t: store %0d wrote %h to %h, expected %h to %h",
                         $time, n, data, addr, exp_data[n], exp_addr[n]);
            end
            n++;
        end
        count = n;
    endtask

    initial begin
        reset        = 1'b1;
        bus_wait     = 1'b1;
        bus_rddata   = '0;
        seed         = 32'h41ff_0f52;
        reset_cycles = 0;
        seen_first   = 1'b0;
        value_errors = 0;
        other_errors = 0;
        build_program();
        check_stores(checked);
        $display("Stores checked: %0d of %0d, value errors: %0d, other errors: %0d",
                 checked, exp_addr.size(), value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
verilog/rv_isa_pkg.sv
verilog/cpu_bus_pkg.sv
verilog/cpu_decode.sv
verilog/cpu_regfile.sv
verilog/cpu_alu.sv
verilog/cpu_control.sv
verilog/cpu.sv
verif/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
    -f tb.f --top-module cpu_tb -o cpu_tb_sim || exit 1
sim_out="$(./obj_dir/cpu_tb_sim)"
printf '%s\n' "$sim_out"
grep -qx "TEST RESULT: PASS" <<< "$sim_out" && exit 0 || exit 1
